// File: include/conv_defines.svh
`ifndef CONV_DEFINES_SVH
`define CONV_DEFINES_SVH

// Pixel and weight width
`define PIXEL_W 8

// Pixels in one image row
`define ROW_PIXELS 8

// Rows held in the row file, also compute cycles per kernel
`define FRAME_ROWS 8

// Row and weight input word width
`define WORD_W 64

// Kernel geometry
`define KERNEL_TAPS 9
`define KERNEL_COUNT 4

// Weight store depth in words, 320 bits with the low 288 in use
`define WEIGHT_WORDS 5

// Window sum width, wide enough for nine full-scale products
`define SUM_W 20

`endif

// File: hdl/convPkg.sv
`include "conv_defines.svh"

package convPkg;

	// Control code on the ctrl input
	typedef enum logic [1:0] {
		ctrlEnd = 2'd0,
		ctrlStart = 2'd1,
		ctrlHold = 2'd2
	} ctrlOp_e;

	typedef enum logic [1:0] {
		stWait,
		stCompute,
		stFinish
	} convState_e;

	typedef logic [`PIXEL_W-1:0] pixel_t;

	// Pixel p sits at bits 8p+7:8p
	typedef pixel_t [`ROW_PIXELS-1:0] row_t;

	// Three rows seen by every window unit, rowA is the oldest
	typedef struct packed {
		row_t rowC;
		row_t rowB;
		row_t rowA;
	} window3_t;

	// Tap 3r+c weights row r at column offset c
	typedef pixel_t [`KERNEL_TAPS-1:0] kernel_t;

	typedef logic [`SUM_W-1:0] windowSum_t;
	typedef windowSum_t [`ROW_PIXELS-1:0] windowSums_t;

endpackage

// File: hdl/convControl.sv
`timescale 1ns/1ps

module convControl (
	input logic clk,
	input logic rst,
	input convPkg::ctrlOp_e ctrl,
	input logic inValid,
	input logic weightValid,
	output logic rowShift,
	output logic weightWrite,
	output logic computing,
	output logic holdClear,
	output logic finish
);

	convPkg::convState_e state;
	convPkg::convState_e stateNext;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= convPkg::stWait;
		end else begin
			state <= stateNext;
		end
	end

	always_comb begin
		stateNext = state;
		case (state)
			convPkg::stWait: begin
				if (ctrl == convPkg::ctrlStart) begin
					stateNext = convPkg::stCompute;
				end else if (ctrl == convPkg::ctrlEnd) begin
					stateNext = convPkg::stFinish;
				end
			end
			convPkg::stCompute: begin
				if (ctrl == convPkg::ctrlHold) begin
					stateNext = convPkg::stWait;
				end else if (ctrl == convPkg::ctrlEnd) begin
					stateNext = convPkg::stFinish;
				end
			end
			convPkg::stFinish: stateNext = convPkg::stFinish;   // Only reset leaves
			default: stateNext = convPkg::stWait;
		endcase
	end

	// Loads happen only while waiting, a row beats a weight word
	assign rowShift = (state == convPkg::stWait) && inValid;
	assign weightWrite = (state == convPkg::stWait) && weightValid && !inValid;

	assign computing = (state == convPkg::stCompute);
	assign holdClear = computing && (ctrl == convPkg::ctrlHold);
	assign finish = (state == convPkg::stFinish);

endmodule

// File: hdl/rowBuffer.sv
`timescale 1ns/1ps
`include "conv_defines.svh"

module rowBuffer (
	input logic clk,
	input logic rst,
	input logic rowShift,
	input logic computing,
	input convPkg::row_t inData,
	output convPkg::window3_t window
);

	convPkg::row_t rows [`FRAME_ROWS];
	convPkg::row_t tailNext;

	// Load feeds the top from outside, compute wraps row 0 around
	assign tailNext = rowShift ? inData : rows[0];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < `FRAME_ROWS; i++) begin
				rows[i] <= '0;
			end
		end else if (rowShift || computing) begin
			for (int i = 0; i < `FRAME_ROWS - 1; i++) begin
				rows[i] <= rows[i + 1];   // Every row moves down one place
			end
			rows[`FRAME_ROWS - 1] <= tailNext;
		end
	end

	// Oldest three rows form the window
	assign window = '{rowC: rows[2], rowB: rows[1], rowA: rows[0]};

endmodule

// File: hdl/kernelBank.sv
`timescale 1ns/1ps
`include "conv_defines.svh"

module kernelBank (
	input logic clk,
	input logic rst,
	input logic weightWrite,
	input convPkg::row_t weightData,
	input logic computing,
	input logic holdClear,
	output convPkg::kernel_t kernel
);

	localparam int StoreW = `WEIGHT_WORDS * `WORD_W;
	localparam int KernelW = `KERNEL_TAPS * `PIXEL_W;
	localparam int WordCntW = $clog2(`WEIGHT_WORDS + 1);
	localparam int CycleW = $clog2(`FRAME_ROWS);
	localparam int KernelIdxW = $clog2(`KERNEL_COUNT);

	logic [StoreW-1:0] store;
	logic [WordCntW-1:0] wordCnt;   // Saturates at WEIGHT_WORDS
	logic [CycleW-1:0] cycleCnt;
	logic [KernelIdxW-1:0] kernelIdx;
	logic storeFull;
	logic frameDone;

	assign storeFull = (wordCnt >= WordCntW'(`WEIGHT_WORDS));
	assign frameDone = (cycleCnt == CycleW'(`FRAME_ROWS - 1));

	// Weight words fill from the bottom of the store
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			store <= '0;
			wordCnt <= '0;
		end else if (holdClear) begin
			store <= '0;
			wordCnt <= '0;
		end else if (weightWrite && !storeFull) begin
			store[wordCnt * `WORD_W +: `WORD_W] <= weightData;
			wordCnt <= wordCnt + 1'b1;
		end
	end

	// One kernel per frame of compute cycles
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cycleCnt <= '0;
			kernelIdx <= '0;
		end else if (holdClear) begin
			cycleCnt <= '0;
			kernelIdx <= '0;
		end else if (computing) begin
			cycleCnt <= cycleCnt + 1'b1;   // Wraps at FRAME_ROWS
			if (frameDone) begin
				kernelIdx <= kernelIdx + 1'b1;   // Wraps modulo KERNEL_COUNT
			end
		end
	end

	// Kernel k is bytes 9k to 9k+8 of the store
	assign kernel = store[kernelIdx * KernelW +: KernelW];

endmodule

// File: hdl/windowMac.sv
`timescale 1ns/1ps
`include "conv_defines.svh"

module windowMac #(
	parameter int column = 0
) (
	input logic clk,
	input logic rst,
	input convPkg::window3_t window,
	input convPkg::kernel_t kernel,
	input logic inValid,
	output convPkg::windowSum_t sum,
	output logic sumValid
);

	localparam int ProdW = 2 * `PIXEL_W;
	localparam int WinSize = 3;

	convPkg::row_t winRows [WinSize];
	logic [`KERNEL_TAPS-1:0][ProdW-1:0] prodNext;
	logic [`KERNEL_TAPS-1:0][ProdW-1:0] prodReg;
	logic prodValid;
	convPkg::windowSum_t total;

	// Row r of the kernel, A is 0
	assign winRows[0] = window.rowA;
	assign winRows[1] = window.rowB;
	assign winRows[2] = window.rowC;

	// Columns wrap around the row edge
	always_comb begin
		for (int r = 0; r < WinSize; r++) begin
			for (int c = 0; c < WinSize; c++) begin
				prodNext[WinSize * r + c] =
					ProdW'(winRows[r][(column + c) % `ROW_PIXELS]) *
					ProdW'(kernel[WinSize * r + c]);
			end
		end
	end

	always_comb begin
		total = '0;
		for (int t = 0; t < `KERNEL_TAPS; t++) begin
			total = total + `SUM_W'(prodReg[t]);
		end
	end

	// Stage 1 products
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			prodReg <= '0;
			prodValid <= 1'b0;
		end else begin
			prodReg <= prodNext;
			prodValid <= inValid;
		end
	end

	// Stage 2 window total
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			sum <= '0;
			sumValid <= 1'b0;
		end else begin
			sum <= total;
			sumValid <= prodValid;
		end
	end

endmodule

// File: hdl/convArray.sv
`timescale 1ns/1ps
`include "conv_defines.svh"

module convArray (
	input logic clk,
	input logic rst,
	input convPkg::ctrlOp_e ctrl,
	input convPkg::row_t inData,
	input logic inValid,
	input convPkg::row_t weightData,
	input logic weightValid,
	output convPkg::windowSums_t results,
	output logic resultValid,
	output logic finish
);

	logic rowShift;
	logic weightWrite;
	logic computing;
	logic holdClear;
	convPkg::window3_t window;
	convPkg::kernel_t kernel;
	logic [`ROW_PIXELS-1:0] unitValid;

	convControl control (
		.clk(clk),
		.rst(rst),
		.ctrl(ctrl),
		.inValid(inValid),
		.weightValid(weightValid),
		.rowShift(rowShift),
		.weightWrite(weightWrite),
		.computing(computing),
		.holdClear(holdClear),
		.finish(finish)
	);

	rowBuffer rows (
		.clk(clk),
		.rst(rst),
		.rowShift(rowShift),
		.computing(computing),
		.inData(inData),
		.window(window)
	);

	kernelBank weights (
		.clk(clk),
		.rst(rst),
		.weightWrite(weightWrite),
		.weightData(weightData),
		.computing(computing),
		.holdClear(holdClear),
		.kernel(kernel)
	);

	// One unit per starting column, all share window and kernel
	for (genvar n = 0; n < `ROW_PIXELS; n++) begin : genUnit
		windowMac #(.column(n)) mac (
			.clk(clk),
			.rst(rst),
			.window(window),
			.kernel(kernel),
			.inValid(computing),
			.sum(results[n]),
			.sumValid(unitValid[n])
		);
	end

	assign resultValid = unitValid[0];   // Units run in lockstep

endmodule

// File: sim/convArrayTb.sv
`timescale 1ns/1ps
`include "conv_defines.svh"

module convArrayTb;

	localparam int NumTests = 6;
	localparam int ClkPeriod = 10;
	localparam int ResetCycles = 16;
	localparam int DrainCycles = 4;
	localparam int KernelW = `KERNEL_TAPS * `PIXEL_W;

	// One table column per field
	localparam int RowLoads [NumTests] = '{8, 0, 0, 0, 2, 0};
	localparam int WeightLoads [NumTests] = '{5, 5, 0, 6, 5, 5};
	localparam int ComputeCycles [NumTests] = '{1, 34, 3, 5, 4, 2};
	localparam bit EndRun [NumTests] = '{0, 0, 0, 0, 0, 1};
	localparam bit BothValid [NumTests] = '{0, 0, 0, 0, 1, 0};

	string testNames [NumTests] = '{
		"singleCycle", "longRun", "clearedWeights",
		"reloadWeights", "rowBeatsWeight", "finishRun"
	};

	logic clk;
	logic rst;
	convPkg::ctrlOp_e ctrl;
	convPkg::row_t inData;
	logic inValid;
	convPkg::row_t weightData;
	logic weightValid;
	convPkg::windowSums_t results;
	logic resultValid;
	logic finish;

	// Reference model of rows, store and counters
	convPkg::row_t mRows [`FRAME_ROWS];
	logic [`WEIGHT_WORDS*`WORD_W-1:0] mStore;
	int mWordCnt;
	int mCycleCnt;
	int mKernelIdx;
	convPkg::convState_e mState;

	convPkg::windowSums_t expQ [$];
	int dueQ [$];   // Cycle at which each prediction must show up
	int cycNum;
	logic [31:0] rngState;
	string curTest;

	convArray uut (
		.clk(clk),
		.rst(rst),
		.ctrl(ctrl),
		.inData(inData),
		.inValid(inValid),
		.weightData(weightData),
		.weightValid(weightValid),
		.results(results),
		.resultValid(resultValid),
		.finish(finish)
	);

	initial begin
		clk = 1'b0;
		forever #(ClkPeriod / 2) clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [63:0] randomWord();
		logic [63:0] w;
		rngState = xorshift32(rngState);
		w[63:32] = rngState;
		rngState = xorshift32(rngState);
		w[31:0] = rngState;
		return w;
	endfunction

	task automatic checkValue(input string what, input logic [63:0] expected,
			input logic [63:0] actual);
		if (actual !== expected) begin
			$display("CHECK FAILED test=%s %s expected=%0h actual=%0h",
				curTest, what, expected, actual);
			$display("Simulation failed");
			$fatal(1, "Value mismatch on %s", what);
		end
	endtask

	// Window n covers columns n..n+2 modulo 8 over the three oldest rows
	function automatic convPkg::windowSums_t predictSums();
		convPkg::windowSums_t sums;
		logic [KernelW-1:0] k;
		int acc;
		k = mStore[mKernelIdx * KernelW +: KernelW];
		for (int n = 0; n < `ROW_PIXELS; n++) begin
			acc = 0;
			for (int r = 0; r < 3; r++) begin
				for (int c = 0; c < 3; c++) begin
					acc = acc + int'(mRows[r][(n + c) % `ROW_PIXELS]) *
						int'(k[(3 * r + c) * `PIXEL_W +: `PIXEL_W]);
				end
			end
			sums[n] = `SUM_W'(acc);
		end
		return sums;
	endfunction

	// Applies one rising edge to the model
	task automatic modelEdge(input convPkg::ctrlOp_e op, input logic inV,
			input convPkg::row_t inD, input logic wV, input convPkg::row_t wD);
		convPkg::row_t oldest;
		case (mState)
			convPkg::stWait: begin
				if (inV) begin
					for (int i = 0; i < `FRAME_ROWS - 1; i++) begin
						mRows[i] = mRows[i + 1];
					end
					mRows[`FRAME_ROWS - 1] = inD;
				end else if (wV && mWordCnt < `WEIGHT_WORDS) begin
					mStore[mWordCnt * `WORD_W +: `WORD_W] = wD;
					mWordCnt++;
				end
				if (op == convPkg::ctrlStart) begin
					mState = convPkg::stCompute;
				end else if (op == convPkg::ctrlEnd) begin
					mState = convPkg::stFinish;
				end
			end
			convPkg::stCompute: begin
				expQ.push_back(predictSums());
				dueQ.push_back(cycNum + 2);
				oldest = mRows[0];   // Rotation
				for (int i = 0; i < `FRAME_ROWS - 1; i++) begin
					mRows[i] = mRows[i + 1];
				end
				mRows[`FRAME_ROWS - 1] = oldest;
				if (op == convPkg::ctrlHold) begin
					mStore = '0;
					mWordCnt = 0;
					mCycleCnt = 0;
					mKernelIdx = 0;
					mState = convPkg::stWait;
				end else begin
					mCycleCnt++;
					if (mCycleCnt == `FRAME_ROWS) begin
						mCycleCnt = 0;
						mKernelIdx = (mKernelIdx + 1) % `KERNEL_COUNT;
					end
					if (op == convPkg::ctrlEnd) begin
						mState = convPkg::stFinish;
					end
				end
			end
			default: ;
		endcase
	endtask

	task automatic checkOutputs();
		convPkg::windowSums_t expected;
		checkValue("finish", mState == convPkg::stFinish, finish);
		if (dueQ.size() > 0 && dueQ[0] == cycNum) begin
			expected = expQ.pop_front();
			void'(dueQ.pop_front());
			checkValue("resultValid", 1, resultValid);
			for (int n = 0; n < `ROW_PIXELS; n++) begin
				checkValue($sformatf("sum %0d", n), expected[n], results[n]);
			end
		end else begin
			checkValue("resultValid", 0, resultValid);
		end
	endtask

	// Outputs are checked before new inputs go out on the falling edge
	task automatic stepCycle(input convPkg::ctrlOp_e op, input logic inV,
			input convPkg::row_t inD, input logic wV, input convPkg::row_t wD);
		@(negedge clk);
		cycNum++;
		checkOutputs();
		ctrl = op;
		inValid = inV;
		inData = inD;
		weightValid = wV;
		weightData = wD;
		modelEdge(op, inV, inD, wV, wD);
	endtask

	task automatic runTest(input int idx);
		convPkg::ctrlOp_e lastOp;
		convPkg::ctrlOp_e drainOp;
		curTest = testNames[idx];
		lastOp = EndRun[idx] ? convPkg::ctrlEnd : convPkg::ctrlHold;
		drainOp = EndRun[idx] ? convPkg::ctrlStart : convPkg::ctrlHold;
		for (int i = 0; i < RowLoads[idx]; i++) begin
			stepCycle(convPkg::ctrlHold, 1'b1, randomWord(), BothValid[idx] && i == 0,
				randomWord());
		end
		for (int i = 0; i < WeightLoads[idx]; i++) begin
			stepCycle(convPkg::ctrlHold, 1'b0, '0, 1'b1, randomWord());
		end
		stepCycle(convPkg::ctrlStart, 1'b0, '0, 1'b0, '0);   // Leaves stWait
		for (int i = 0; i < ComputeCycles[idx] - 1; i++) begin
			stepCycle(convPkg::ctrlStart, 1'b0, '0, 1'b0, '0);
		end
		stepCycle(lastOp, 1'b0, '0, 1'b0, '0);
		for (int i = 0; i < DrainCycles; i++) begin
			stepCycle(drainOp, 1'b0, '0, 1'b0, '0);
		end
		checkValue("pending results", 0, dueQ.size());
	endtask

	initial begin
		rst = 1'b1;
		ctrl = convPkg::ctrlHold;   // Idle code with no effect in stWait
		inData = '0;
		inValid = 1'b0;
		weightData = '0;
		weightValid = 1'b0;
		rngState = 32'd33;
		cycNum = 0;
		curTest = "reset";
		for (int i = 0; i < `FRAME_ROWS; i++) begin
			mRows[i] = '0;
		end
		mStore = '0;
		mWordCnt = 0;
		mCycleCnt = 0;
		mKernelIdx = 0;
		mState = convPkg::stWait;

		repeat (ResetCycles) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		checkValue("resultValid", 0, resultValid);
		checkValue("finish", 0, finish);
		for (int n = 0; n < `ROW_PIXELS; n++) begin
			checkValue($sformatf("sum %0d", n), 0, results[n]);
		end

		for (int t = 0; t < NumTests; t++) begin
			runTest(t);
		end

		$display("Simulation passed");
		$finish;
	end

	initial begin : watchdog
		int limit;
		limit = ResetCycles;
		for (int t = 0; t < NumTests; t++) begin
			limit = limit + 4 * (RowLoads[t] + WeightLoads[t] + ComputeCycles[t]);
		end
		#(limit * ClkPeriod);
		$display("Timeout: the run did not complete within %0d cycles", limit);
		$display("Simulation failed");
		$fatal(1, "Watchdog expired");
	end

endmodule

// File: sources.f
+incdir+include
hdl/convPkg.sv
hdl/convControl.sv
hdl/rowBuffer.sv
hdl/kernelBank.sv
hdl/windowMac.sv
hdl/convArray.sv
sim/convArrayTb.sv

// File: Bender.yml
package:
  name: convArray

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/convPkg.sv
      - hdl/convControl.sv
      - hdl/rowBuffer.sv
      - hdl/kernelBank.sv
      - hdl/windowMac.sv
      - hdl/convArray.sv
  - target: test
    include_dirs:
      - include
    files:
      - sim/convArrayTb.sv
